// File: Bender.yml
package:
  name: te_trace_encoder

sources:
  - src/te_pkg.sv
  - src/te_reg_if.sv
  - src/te_event_decoder.sv
  - src/te_branch_map.sv
  - src/te_packet_emitter.sv
  - src/te_trace_encoder.sv
  - target: test
    files:
      - bench/tb_te_trace_encoder.sv

// File: all.f
src/te_pkg.sv
src/te_reg_if.sv
src/te_event_decoder.sv
src/te_branch_map.sv
src/te_packet_emitter.sv
src/te_trace_encoder.sv
bench/tb_te_trace_encoder.sv

// File: bench/tb_te_trace_encoder.sv
/*
 * tb_te_trace_encoder
 * pattern-driven testbench for the trace encoder that drives retirements
 * and wishbone accesses and scoreboards packets under random back-pressure
 */
module tb_te_trace_encoder import te_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam string PATTERN_FILE = "bench/te_patterns.txt";
    localparam int    BP_SEED      = 90849;
    localparam int    DRAIN_CYCLES = 10;

    // one line of the pattern file with fields already in DUT types
    typedef struct packed {
        logic [7:0]  kind;
        wb_addr_t    adr;
        wb_data_t    dat;
        retire_t     beat;
        logic [15:0] reps;
        packet_t     pkt;
    } record_t;

    logic     clk_i;
    logic     arst_n_i;
    retire_t  retire_i;
    logic     ready_o;
    packet_t  packet_o;
    logic     packet_valid_o;
    logic     packet_ready_i;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    wb_addr_t wb_adr_i;
    wb_data_t wb_dat_i;
    wb_data_t wb_dat_o;
    logic     wb_ack_o;

    record_t  recs[$];
    packet_t  expect_q[$];
    packet_t  exp_pkt;
    wb_data_t rdata;
    int       cycle_cnt;
    int       cycle_limit;

    te_trace_encoder dut_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .retire_i       (retire_i),
        .ready_o        (ready_o),
        .packet_o       (packet_o),
        .packet_valid_o (packet_valid_o),
        .packet_ready_i (packet_ready_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_packet(input packet_t got, input packet_t exp);
        if (got !== exp) begin
            $display("[ERROR] %t packet got fmt=%0d sub=%0d len=%0d payload=%h",
                     $time, got.format, got.subformat, got.length, got.payload);
            $display("[ERROR] %t packet exp fmt=%0d sub=%0d len=%0d payload=%h",
                     $time, exp.format, exp.subformat, exp.length, exp.payload);
            abort_run();
        end
    endtask

    task automatic check_word(input wb_addr_t adr, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %t register %0d read %h, expected %h", $time, adr, got, exp);
            abort_run();
        end
    endtask

    // parse the whole pattern file up front and skip lines starting with #
    task automatic load_patterns(output int beats);
        int                   fd;
        int                   code;
        int                   want;
        string                tag;
        string                rest;
        record_t              rec;
        logic [31:0]          t [6];
        logic [PAYLOAD_W-1:0] wide;
        beats = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PATTERN_FILE);
            abort_run();
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag[0] == "#") begin
                void'($fgets(rest, fd));
                continue;
            end
            rec      = '0;
            rec.kind = tag[0];
            case (tag)
                "W", "R": begin
                    want    = 2;
                    code    = $fscanf(fd, "%h %h", t[0], t[1]);
                    rec.adr = t[0][3:0];
                    rec.dat = t[1];
                    beats   = beats + 1;
                end
                "I": begin
                    want             = 6;
                    code             = $fscanf(fd, "%h %h %h %h %h %h",
                                               t[0], t[1], t[2], t[3], t[4], t[5]);
                    rec.beat.valid   = 1'b1;
                    rec.beat.iaddr   = t[0];
                    rec.beat.itype   = itype_e'(t[1][2:0]);
                    rec.beat.priv    = t[2][1:0];
                    rec.beat.cause   = t[3][4:0];
                    rec.beat.tval    = t[4];
                    rec.reps         = t[5][15:0];
                    beats            = beats + int'(rec.reps);
                end
                "P": begin
                    want                = 4;
                    code                = $fscanf(fd, "%h %h %h %h", t[0], t[1], t[2], wide);
                    rec.pkt.format      = format_e'(t[0][1:0]);
                    rec.pkt.subformat   = sync_sub_e'(t[1][1:0]);
                    rec.pkt.length      = t[2][3:0];
                    rec.pkt.payload     = wide;
                    beats               = beats + 1;
                end
                default: begin
                    $display("unknown record kind %s in pattern file", tag);
                    abort_run();
                end
            endcase
            if (code != want) begin
                $display("malformed %s record in pattern file", tag);
                abort_run();
            end
            recs.push_back(rec);
        end
        $fclose(fd);
    endtask

    task automatic write_register(input wb_addr_t adr, input wb_data_t dat);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        @(negedge clk_i);
        while (!wb_ack_o) @(negedge clk_i);
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic read_register(input wb_addr_t adr, output wb_data_t dat);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= adr;
        @(negedge clk_i);
        while (!wb_ack_o) @(negedge clk_i);
        // data is valid while ack is high
        dat = wb_dat_o;
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    // back-to-back beats with the address stepping one instruction per repeat
    task automatic drive_retirement(input retire_t first, input int reps);
        retire_t beat;
        int      k;
        beat = first;
        @(posedge clk_i);
        for (k = 0; k < reps; k++) begin
            retire_i <= beat;
            @(negedge clk_i);
            while (!ready_o) @(negedge clk_i);
            // beat transfers on this edge
            @(posedge clk_i);
            beat.iaddr = beat.iaddr + 32'd4;
        end
        retire_i <= '0;
    endtask

    // random sink stall with ready about three cycles in four
    initial begin
        packet_ready_i = 1'b0;
        void'($urandom(BP_SEED));
        forever begin
            @(posedge clk_i);
            packet_ready_i <= ($urandom % 4) != 0;
        end
    end

    // scoreboard sees each transfer at the negedge before its clock edge
    always @(negedge clk_i) begin
        if (arst_n_i && packet_valid_o && packet_ready_i) begin
            if (expect_q.size() == 0) begin
                $display("packet at %t arrived with nothing expected", $time);
                abort_run();
            end else begin
                exp_pkt = expect_q.pop_front();
                check_packet(packet_o, exp_pkt);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        cycle_cnt   = 0;
        cycle_limit = 0;
        arst_n_i    = 1'b0;
        retire_i    = '0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        load_patterns(cycle_limit);
        cycle_limit = cycle_limit * 40 + 200;
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;
        foreach (recs[i]) begin
            case (recs[i].kind)
                "W": write_register(recs[i].adr, recs[i].dat);
                "R": begin
                    // count register only settles once every packet is out
                    while (expect_q.size() != 0) @(posedge clk_i);
                    read_register(recs[i].adr, rdata);
                    check_word(recs[i].adr, rdata, recs[i].dat);
                end
                "I": drive_retirement(recs[i].beat, int'(recs[i].reps));
                "P": expect_q.push_back(recs[i].pkt);
                default: ;
            endcase
        end
        while (expect_q.size() != 0) @(posedge clk_i);
        // idle a little so a stray packet still gets caught
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: bench/te_patterns.txt
# W/R: adr data | I: iaddr itype priv cause tval repeat | P: format subformat length payload
# all fields hex, itype 0 seq 1 taken 2 not-taken 3 jump 4 exception 5 interrupt
# enable with ioptions 5, support then start
W 0 51
P 3 3 2 51f
I 80000000 0 3 0 0 1
P 3 0 5 4000000073
# illegal instruction trap, handler gives the trap packet
I 80000004 4 3 2 deadbeef 1
I 80000200 0 3 0 0 1
P 3 1 a 37ab6fbbe00000802177
# jump without pending branches
I 80000204 3 3 0 0 1
I 80000400 0 3 0 0 1
P 2 0 5 200001002
# jump with two pending branches
I 80000404 1 3 0 0 1
I 80000408 2 3 0 0 1
I 8000040c 3 3 0 0 1
I 80000800 0 3 0 0 1
P 1 0 9 200002000000000109
# 16 taken then 15 not taken fill the map
I 80000804 1 3 0 0 10
I 80000844 2 3 0 0 f
P 1 0 5 3fff80007d
# privilege change, then resync after 3 retirements
I 80000880 0 1 0 0 1
P 3 0 5 4000044033
W 1 3
I 80000884 0 1 0 0 2
I 8000088c 1 1 0 0 1
P 3 0 5 4000044623
W 1 0
# packet count, write to it is ignored
R 2 8
W 2 ffff
R 2 8
R 0 51
# interrupt trap
I 80000890 5 1 7 0 1
I 80000100 0 3 0 0 1
P 3 1 a 2000004033f7
# jump chain under back-pressure
I 80000104 3 3 0 0 1
I 80000108 3 3 0 0 1
P 2 0 5 200000422
I 8000010c 3 3 0 0 1
P 2 0 5 200000432
I 80000110 3 3 0 0 1
P 2 0 5 200000442
I 80000200 0 3 0 0 1
P 2 0 5 200000802
R 2 d
# disable, nothing traced afterwards
W 0 50
P 3 3 2 54f
I 80000300 0 3 0 0 1
R 2 e

// File: src/te_branch_map.sv
/*
 * te_branch_map
 * execute stage, accumulates branch outcomes and counts them
 */
module te_branch_map import te_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    record_i,
    input  logic    taken_i,
    input  logic    clear_i,
    output bcount_t count_o,
    output bmap_t   map_o,
    output logic    full_o
);

    bcount_t count_q;
    bmap_t   map_q;

    assign count_o = count_q;
    assign map_o   = map_q;
    assign full_o  = count_q == bcount_t'(BMAP_W);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
            map_q   <= '0;
        end else if (clear_i) begin
            // clear first, then the new outcome lands in bit 0
            count_q <= record_i ? bcount_t'(1) : '0;
            map_q   <= record_i ? bmap_t'(!taken_i) : '0;
        end else if (record_i) begin
            // 1 marks a not-taken branch
            map_q[count_q] <= !taken_i;
            count_q        <= count_q + 1'b1;
        end
    end

    // decoder never records into a full map unless it flushes it too
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        record_i && full_o |-> clear_i);

endmodule

// File: src/te_event_decoder.sv
/*
 * te_event_decoder
 * decode stage that classifies each retirement and picks the packet
 * format and subformat and holds one event for the emitter
 */
module te_event_decoder import te_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  retire_t retire_i,
    output logic    ready_o,
    input  cfg_t    cfg_i,
    input  logic    bmap_full_i,
    input  bcount_t branches_i,
    output logic    bm_record_o,
    output logic    bm_taken_o,
    output logic    bm_clear_o,
    output event_t  evt_o,
    output logic    evt_valid_o,
    input  logic    evt_ready_i
);

    logic    fire;
    logic    traced;
    logic    en_edge;
    logic    is_br;
    logic    is_trap;
    logic    sync;
    logic    pending;
    logic    rs_hit;
    bcount_t eff_count;
    event_t  evt_d;
    event_t  evt_q;
    // control state
    logic    en_q;
    logic    started_q;
    logic    trap_q;
    logic    jump_q;
    priv_t   last_priv_q;
    logic [RESYNC_W-1:0] rs_cnt_q;
    // record of the last trapping instruction
    cause_t          trap_cause_q;
    logic            trap_int_q;
    logic [XLEN-1:0] trap_tval_q;

    // stall only when the event is stuck behind a held packet
    assign ready_o     = !(evt_q.emit && !evt_ready_i);
    assign evt_o       = evt_q;
    assign evt_valid_o = evt_q.emit;

    assign fire    = retire_i.valid && ready_o;
    // enable edge not yet reported
    assign en_edge = en_q != cfg_i.enable;
    assign traced  = fire && en_q && cfg_i.enable;
    assign is_br   = retire_i.itype inside {IT_BR_TAKEN, IT_BR_NOT};
    assign is_trap = retire_i.itype inside {IT_EXC, IT_INT};

    // map is flushed whenever an event moves into the emitter
    assign bm_clear_o = evt_q.emit && evt_ready_i;
    assign eff_count  = bm_clear_o ? '0 : branches_i;
    // own branch counts as pending since it is recorded first
    assign pending    = is_br || (eff_count != '0);
    assign rs_hit     = (cfg_i.resync_period != '0) &&
                        (rs_cnt_q >= cfg_i.resync_period - 1'b1);

    assign sync        = evt_d.emit && (evt_d.format == F_SYNC);
    // sync packets carry the branch bit instead of recording it
    assign bm_record_o = traced && is_br && !sync;
    assign bm_taken_o  = retire_i.itype == IT_BR_TAKEN;

    // priority ladder of the decode rules
    always_comb begin
        evt_d           = '0;
        evt_d.format    = F_SYNC;
        evt_d.subformat = SF_START;
        evt_d.priv      = retire_i.priv;
        evt_d.iaddr     = retire_i.iaddr;
        evt_d.branch    = retire_i.itype != IT_BR_TAKEN;
        if (en_edge) begin
            evt_d.emit        = 1'b1;
            evt_d.subformat   = SF_SUPPORT;
            // 1 means ended and not traced
            evt_d.qual_status = {1'b0, !cfg_i.enable};
            evt_d.tval        = {{(XLEN-IOPT_W){1'b0}}, cfg_i.ioptions};
        end else if (traced) begin
            evt_d.emit = 1'b1;
            if (!started_q) begin
                // first instruction after enable gives a start packet
            end else if (trap_q) begin
                // handler address with the trapping instruction's record
                evt_d.subformat = SF_TRAP;
                evt_d.cause     = trap_cause_q;
                evt_d.interrupt = trap_int_q;
                evt_d.tval      = trap_tval_q;
            end else if ((retire_i.priv != last_priv_q) || rs_hit) begin
                // privilege change or resync timeout gives a start packet
            end else if (jump_q) begin
                if (pending) begin
                    evt_d.format       = F_DIFF_DELTA;
                    evt_d.with_address = 1'b1;
                end else begin
                    evt_d.format = F_ADDR_ONLY;
                end
            end else if (is_br && (eff_count == BMAP_LAST)) begin
                // this branch fills the map
                evt_d.format = F_DIFF_DELTA;
            end else begin
                evt_d.emit = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            evt_q       <= '0;
            en_q        <= 1'b0;
            started_q   <= 1'b0;
            trap_q      <= 1'b0;
            jump_q      <= 1'b0;
            last_priv_q <= '0;
            rs_cnt_q    <= '0;
        end else begin
            if (ready_o) begin
                evt_q <= evt_d;
            end
            if (ready_o && en_edge) begin
                en_q      <= cfg_i.enable;
                started_q <= 1'b0;
                trap_q    <= 1'b0;
                jump_q    <= 1'b0;
                rs_cnt_q  <= '0;
            end else if (traced) begin
                started_q   <= 1'b1;
                trap_q      <= is_trap;
                jump_q      <= retire_i.itype == IT_JUMP;
                last_priv_q <= retire_i.priv;
                rs_cnt_q    <= sync ? '0 : rs_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trap_cause_q <= '0;
            trap_int_q   <= 1'b0;
            trap_tval_q  <= '0;
        end else if (traced && is_trap) begin
            trap_cause_q <= retire_i.cause;
            trap_int_q   <= retire_i.itype == IT_INT;
            trap_tval_q  <= retire_i.tval;
        end
    end

    // held event stays put until the emitter takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        evt_valid_o && !evt_ready_i |=> $stable(evt_o));

    // a full map always has the event that flushes it queued here
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        bmap_full_i |-> evt_valid_o);

endmodule

// File: src/te_packet_emitter.sv
/*
 * te_packet_emitter
 * result stage that assembles payload and length per format and holds
 * the packet until the sink accepts it
 */
module te_packet_emitter import te_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  event_t  evt_i,
    input  logic    evt_valid_i,
    input  bcount_t count_i,
    input  bmap_t   map_i,
    output logic    evt_ready_o,
    output packet_t packet_o,
    output logic    packet_valid_o,
    input  logic    packet_ready_i,
    output logic    pkt_sent_o
);

    packet_t pkt_d;
    packet_t pkt_q;
    logic    valid_q;
    logic    load;
    // support packet reports tracing on when qual_status is 0
    logic    ienable;

    assign evt_ready_o    = !valid_q || packet_ready_i;
    assign load           = evt_valid_i && evt_ready_o;
    assign pkt_sent_o     = valid_q && packet_ready_i;
    assign packet_o       = pkt_q;
    assign packet_valid_o = valid_q;
    assign ienable        = !evt_i.qual_status[0];

    // fields packed from bit 0 upward with the upper bits zero
    always_comb begin
        pkt_d           = '0;
        pkt_d.format    = evt_i.format;
        pkt_d.subformat = evt_i.subformat;
        case (evt_i.format)
            F_SYNC: begin
                case (evt_i.subformat)
                    SF_START: begin
                        pkt_d.payload = payload_t'({evt_i.iaddr, evt_i.priv, evt_i.branch,
                                                    evt_i.subformat, evt_i.format});
                        pkt_d.length  = LEN_START;
                    end
                    SF_TRAP: begin
                        // thaddr is always 1 and the address is the handler
                        pkt_d.payload = payload_t'({evt_i.tval, evt_i.iaddr, 1'b1,
                                                    evt_i.interrupt, evt_i.cause, evt_i.priv,
                                                    evt_i.branch, evt_i.subformat,
                                                    evt_i.format});
                        pkt_d.length  = LEN_TRAP;
                    end
                    SF_SUPPORT: begin
                        // encoder_mode 0 selects branch trace only
                        pkt_d.payload = payload_t'({evt_i.tval[IOPT_W-1:0], evt_i.qual_status,
                                                    1'b0, ienable, evt_i.subformat,
                                                    evt_i.format});
                        pkt_d.length  = LEN_SUPPORT;
                    end
                    // context subformat not generated
                    default: pkt_d.length = '0;
                endcase
            end
            F_ADDR_ONLY: begin
                pkt_d.payload = payload_t'({evt_i.iaddr, evt_i.format});
                pkt_d.length  = LEN_ADDR_ONLY;
            end
            F_DIFF_DELTA: begin
                if (evt_i.with_address) begin
                    pkt_d.payload = payload_t'({evt_i.iaddr, map_i, count_i, evt_i.format});
                    pkt_d.length  = LEN_F1_ADDR;
                end else begin
                    // full map sent without an address
                    pkt_d.payload = payload_t'({map_i, count_i, evt_i.format});
                    pkt_d.length  = LEN_F1_NOADDR;
                end
            end
            // format 0 not supported
            default: pkt_d.length = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (packet_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // packet held stable while the sink stalls
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pkt_q <= '0;
        end else if (load) begin
            pkt_q <= pkt_d;
        end
    end

    // nothing set beyond the reported byte length
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        packet_valid_o |-> (packet_o.payload >> {packet_o.length, 3'b000}) == '0);

endmodule

// File: src/te_pkg.sv
/*
 * te_pkg
 * widths, encodings, structs and register map shared by the
 * E-Trace instruction trace encoder
 */
package te_pkg;

    localparam int XLEN      = 32;
    localparam int PAYLOAD_W = 80;
    localparam int BMAP_W    = 31;
    localparam int IOPT_W    = 4;
    localparam int RESYNC_W  = 16;

    typedef logic [XLEN-1:0]      iaddr_t;
    typedef logic [1:0]           priv_t;
    typedef logic [4:0]           cause_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;
    // payload length in bytes
    typedef logic [3:0]           plen_t;
    typedef logic [4:0]           bcount_t;
    // bit n is the n-th branch, 1 means not taken
    typedef logic [BMAP_W-1:0]    bmap_t;
    typedef logic [3:0]           wb_addr_t;
    typedef logic [31:0]          wb_data_t;

    // count at which one more branch fills the map
    localparam bcount_t BMAP_LAST = bcount_t'(BMAP_W - 1);

    // payload lengths, bit count rounded up to bytes
    localparam plen_t LEN_START     = 4'd5;
    localparam plen_t LEN_TRAP      = 4'd10;
    localparam plen_t LEN_SUPPORT   = 4'd2;
    localparam plen_t LEN_ADDR_ONLY = 4'd5;
    localparam plen_t LEN_F1_ADDR   = 4'd9;
    localparam plen_t LEN_F1_NOADDR = 4'd5;

    // register map, word addresses
    localparam wb_addr_t REG_CTRL   = 4'd0;
    localparam wb_addr_t REG_RESYNC = 4'd1;
    localparam wb_addr_t REG_PKTCNT = 4'd2;
    // control register fields
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_IOPT_LSB = 4;

    // retirement class, IT_JUMP is an uninferable jump
    typedef enum logic [2:0] {
        IT_SEQ      = 3'd0,
        IT_BR_TAKEN = 3'd1,
        IT_BR_NOT   = 3'd2,
        IT_JUMP     = 3'd3,
        IT_EXC      = 3'd4,
        IT_INT      = 3'd5
    } itype_e;

    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'd0,
        F_DIFF_DELTA = 2'd1,
        F_ADDR_ONLY  = 2'd2,
        F_SYNC       = 2'd3
    } format_e;

    typedef enum logic [1:0] {
        SF_START   = 2'd0,
        SF_TRAP    = 2'd1,
        SF_CONTEXT = 2'd2,
        SF_SUPPORT = 2'd3
    } sync_sub_e;

    typedef struct packed {
        logic            valid;
        iaddr_t          iaddr;
        itype_e          itype;
        priv_t           priv;
        cause_t          cause;
        logic [XLEN-1:0] tval;
    } retire_t;

    typedef struct packed {
        logic            emit;
        format_e         format;
        sync_sub_e       subformat;
        logic            branch;
        priv_t           priv;
        iaddr_t          iaddr;
        cause_t          cause;
        logic            interrupt;
        // ioptions ride in the low bits for support events
        logic [XLEN-1:0] tval;
        logic [1:0]      qual_status;
        logic            with_address;
    } event_t;

    typedef struct packed {
        format_e   format;
        sync_sub_e subformat;
        plen_t     length;
        payload_t  payload;
    } packet_t;

    typedef struct packed {
        logic                enable;
        logic [IOPT_W-1:0]   ioptions;
        logic [RESYNC_W-1:0] resync_period;
    } cfg_t;

endpackage

// File: src/te_reg_if.sv
/*
 * te_reg_if
 * wishbone classic slave with the trace control, resync period
 * and packet count registers
 */
module te_reg_if import te_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    output cfg_t     cfg_o,
    input  logic     pkt_sent_i
);

    logic     req;
    logic     ack_d;
    logic     ack_q;
    // cycle already answered, wait for stb to drop
    logic     done_q;
    logic     wr_en;
    cfg_t     cfg_q;
    wb_data_t pkt_cnt_q;

    assign req   = wb_cyc_i && wb_stb_i;
    assign ack_d = req && !ack_q && !done_q;
    // write lands on the same edge that raises ack
    assign wr_en = ack_d && wb_we_i;

    assign wb_ack_o = ack_q;
    assign cfg_o    = cfg_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= ack_d;
            done_q <= req && (done_q || ack_q);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q     <= '0;
            pkt_cnt_q <= '0;
        end else begin
            // every transfer on the packet port
            if (pkt_sent_i) begin
                pkt_cnt_q <= pkt_cnt_q + 1'b1;
            end
            if (wr_en) begin
                case (wb_adr_i)
                    REG_CTRL: begin
                        cfg_q.enable   <= wb_dat_i[CTRL_EN_BIT];
                        cfg_q.ioptions <= wb_dat_i[CTRL_IOPT_LSB +: IOPT_W];
                    end
                    REG_RESYNC: cfg_q.resync_period <= wb_dat_i[RESYNC_W-1:0];
                    // packet count is read only, others unmapped
                    default: ;
                endcase
            end
        end
    end

    // read data, sampled by the master while ack is high
    always_comb begin
        wb_dat_o = '0;
        case (wb_adr_i)
            REG_CTRL: begin
                wb_dat_o[CTRL_EN_BIT]              = cfg_q.enable;
                wb_dat_o[CTRL_IOPT_LSB +: IOPT_W]  = cfg_q.ioptions;
            end
            REG_RESYNC: wb_dat_o[RESYNC_W-1:0] = cfg_q.resync_period;
            REG_PKTCNT: wb_dat_o = pkt_cnt_q;
            default:    wb_dat_o = '0;
        endcase
    end

    // an ack only ever answers a strobe from the cycle before
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(wb_ack_o) |-> $past(wb_stb_i && wb_cyc_i));

endmodule

// File: src/te_trace_encoder.sv
/*
 * te_trace_encoder
 * top level, register block feeding the decode, branch map and
 * packet emitter stages
 */
module te_trace_encoder import te_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // retirement ingress
    input  retire_t  retire_i,
    output logic     ready_o,
    // packet egress
    output packet_t  packet_o,
    output logic     packet_valid_o,
    input  logic     packet_ready_i,
    // wishbone classic slave
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o
);

    cfg_t    cfg;
    logic    pkt_sent;
    // decoder to branch map
    logic    bm_record;
    logic    bm_taken;
    logic    bm_clear;
    logic    bm_full;
    bcount_t bm_count;
    bmap_t   bm_map;
    // decoder to emitter
    event_t  evt;
    logic    evt_valid;
    logic    evt_ready;

    te_reg_if reg_if_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .cfg_o      (cfg),
        .pkt_sent_i (pkt_sent)
    );

    te_event_decoder decoder_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .retire_i    (retire_i),
        .ready_o     (ready_o),
        .cfg_i       (cfg),
        .bmap_full_i (bm_full),
        .branches_i  (bm_count),
        .bm_record_o (bm_record),
        .bm_taken_o  (bm_taken),
        .bm_clear_o  (bm_clear),
        .evt_o       (evt),
        .evt_valid_o (evt_valid),
        .evt_ready_i (evt_ready)
    );

    te_branch_map branch_map_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .record_i (bm_record),
        .taken_i  (bm_taken),
        .clear_i  (bm_clear),
        .count_o  (bm_count),
        .map_o    (bm_map),
        .full_o   (bm_full)
    );

    te_packet_emitter emitter_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .evt_i          (evt),
        .evt_valid_i    (evt_valid),
        .count_i        (bm_count),
        .map_i          (bm_map),
        .evt_ready_o    (evt_ready),
        .packet_o       (packet_o),
        .packet_valid_o (packet_valid_o),
        .packet_ready_i (packet_ready_i),
        .pkt_sent_o     (pkt_sent)
    );

endmodule
